// ==== sources.f ====
verilog/sram_pkg.sv
verilog/fetch_pkg.sv
verilog/tile_addr_encode.sv
verilog/fetch_cmd_queue.sv
verilog/burst_reader.sv
verilog/tile_burst_fetch_top.sv
dv/feat_sram_model.sv
dv/tile_burst_fetch_props.sv
dv/tile_burst_fetch_tb.sv

// ==== dv/tile_burst_fetch_tb.sv ====
`timescale 1ns/1ps

module tile_burst_fetch_tb
  import sram_pkg::*;
  import fetch_pkg::*;
();

  // about 60 requests at up to 25 cycles each, plus margin
  localparam int unsigned MAX_CYCLES = 5000;

  logic      clk, arst_n;
  logic      req_valid, req_ready;
  tile_req_t req;
  logic      mem_req_valid, mem_req_ready, mem_rvalid;
  mem_req_t  mem_req;
  mem_word_t mem_rdata;
  logic      feat_valid, feat_ready;
  feat_out_t feat;
  // stall knobs for sram ready and feature sink
  logic      mem_stall, feat_stall, saw_full;

  // pending tiles and pending sram reads, oldest first
  tile_req_t   exp_reqs[$];
  mem_req_t    exp_mem[$];
  int unsigned cycles, feat_low, err_cnt, err_base, tests_run, tests_bad;
  // bound assertion failures already counted
  int unsigned prop_seen;
  string       test_name;

  tile_burst_fetch_top uut (.*);
  feat_sram_model u_sram (.*);

  always #50 clk = ~clk;

  // ------------------------------------------------------------------
  // reference and compares
  // ------------------------------------------------------------------

  // beat k of a tile sits at base + tile index * BEATS + k
  function automatic int unsigned beat_word(tile_row_t row, tile_col_t col, int unsigned k);
    return BASE_ADDR_WORD + (row * TILES_X + col) * BEATS + k;
  endfunction

  // each word is {full word, ~full word}, beat 0 lowest
  function automatic feat_vec_t expected_feat(tile_row_t row, tile_col_t col);
    feat_vec_t   vec;
    int unsigned w;
    for (int unsigned k = 0; k < BEATS; k++) begin
      w = beat_word(row, col, k);
      vec[k*MEM_W +: MEM_W] = {w, ~w};
    end
    return vec;
  endfunction

  task automatic check_feat(feat_vec_t exp, feat_vec_t act);
    if (act !== exp) begin
      $display("ERR %s vec expected %h actual %h", test_name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_tag(tag_t exp, tag_t act);
    if (act !== exp) begin
      $display("ERR %s tag expected %h actual %h", test_name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_req(mem_req_t exp, mem_req_t act);
    if (act !== exp) begin
      $display("ERR %s mem_req expected %h actual %h", test_name, exp, act);
      err_cnt++;
    end
  endtask

  // scoreboard, everything sampled on the rising edge
  always @(posedge clk) begin : compare
    tile_req_t   r;
    mem_req_t    m;
    int unsigned w;
    if (arst_n) begin
      if (req_valid && req_ready) begin
        exp_reqs.push_back(req);
        // banks alternate since the words are consecutive
        for (int unsigned k = 0; k < BEATS; k++) begin
          w      = beat_word(req.row, req.col, k);
          m.bank = bank_t'(w % BANKS);
          m.row  = row_addr_t'(w / BANKS);
          m.tag  = req.tag;
          exp_mem.push_back(m);
        end
      end
      if (mem_req_valid && mem_req_ready) begin
        if (exp_mem.size() == 0) begin
          $display("%s: memory read issued with no burst pending", test_name);
          err_cnt++;
        end else begin
          check_req(exp_mem.pop_front(), mem_req);
        end
      end
      if (feat_valid && feat_ready) begin
        if (exp_reqs.size() == 0) begin
          $display("%s: feature delivered with no request pending", test_name);
          err_cnt++;
        end else begin
          r = exp_reqs.pop_front();
          check_feat(expected_feat(r.row, r.col), feat.vec);
          check_tag(r.tag, feat.tag);
        end
      end
    end
  end

  // feat_ready low for 1 to 10 cycles at random
  always @(posedge clk) begin
    #1;
    if (feat_low > 0) begin
      feat_low--;
    end else if (feat_stall && ($urandom % 4 == 0)) begin
      feat_low = 1 + $urandom % 10;
    end
    feat_ready = (feat_low == 0);
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("run timed out after %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------

  // valid stays high on return, for back-to-back use
  task automatic send_req(tile_row_t row, tile_col_t col, tag_t tag);
    req_valid = 1'b1;
    req.row   = row;
    req.col   = col;
    req.tag   = tag;
    @(posedge clk);
    while (!req_ready) begin
      saw_full = 1'b1;
      @(posedge clk);
    end
    #1;
  endtask

  task automatic drain();
    while (exp_reqs.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic single_req(tile_row_t row, tile_col_t col, tag_t tag);
    send_req(row, col, tag);
    req_valid = 1'b0;
    drain();
  endtask

  task automatic send_random(int unsigned n, tag_t first_tag);
    for (int unsigned i = 0; i < n; i++) begin
      send_req(tile_row_t'($urandom % TILES_Y), tile_col_t'($urandom % TILES_X),
               first_tag + tag_t'(i));
    end
    req_valid = 1'b0;
    drain();
  endtask

  // whatever was in flight is dropped with the reset
  task automatic apply_reset();
    arst_n    = 1'b0;
    req_valid = 1'b0;
    exp_reqs.delete();
    exp_mem.delete();
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
  endtask

  task automatic finish_test();
    int unsigned prop_now;
    // assertion failures in the reader count against the current test
    prop_now  = uut.u_reader.u_props.fail_cnt;
    err_cnt   += prop_now - prop_seen;
    prop_seen = prop_now;
    tests_run++;
    if (err_cnt == err_base) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", test_name, err_cnt - err_base);
    end
    err_base = err_cnt;
  endtask

  initial begin
    void'($urandom(32'hb917_6085));
    clk        = 1'b0;
    req        = '0;
    mem_stall  = 1'b0;
    feat_stall = 1'b0;
    feat_ready = 1'b1;
    saw_full   = 1'b0;
    feat_low   = 0;
    cycles     = 0;
    err_cnt    = 0;
    err_base   = 0;
    prop_seen  = 0;
    tests_run  = 0;
    tests_bad  = 0;
    test_name  = "reset";
    apply_reset();

    test_name = "corner_tiles";
    single_req(3'd0, 4'd0, 8'h01);
    single_req(3'd7, 4'd15, 8'h02);
    single_req(3'd3, 4'd9, 8'h03);
    finish_test();

    test_name = "back_to_back";
    send_random(30, 8'h10);
    finish_test();

    test_name = "mem_stalls";
    mem_stall = 1'b1;
    send_random(12, 8'h40);
    mem_stall = 1'b0;
    finish_test();

    // queue and encoder fill up behind a stalled sink
    test_name  = "feat_backpressure";
    feat_stall = 1'b1;
    saw_full   = 1'b0;
    send_random(15, 8'h60);
    feat_stall = 1'b0;
    if (!saw_full) begin
      $display("%s: req_ready never fell under back-pressure", test_name);
      err_cnt++;
    end
    finish_test();

    test_name = "reset_mid_burst";
    send_req(3'd2, 4'd6, 8'h80);
    req_valid = 1'b0;
    while (!mem_req_valid) begin
      @(posedge clk);
      #1;
    end
    // one beat in, the rest still to go
    @(posedge clk);
    #1;
    apply_reset();
    if (mem_req_valid || feat_valid || !req_ready) begin
      $display("%s: handshake outputs not idle right after reset", test_name);
      err_cnt++;
    end
    single_req(3'd5, 4'd3, 8'h81);
    finish_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== dv/tile_burst_fetch_props.sv ====
`timescale 1ns/1ps

module tile_burst_fetch_props
  import sram_pkg::*;
  import fetch_pkg::*;
(
  input logic      clk,
  input logic      arst_n,
  input logic      mem_req_valid,
  input logic      mem_req_ready,
  input mem_req_t  mem_req,
  input logic      feat_valid,
  input logic      feat_ready,
  input feat_out_t feat,
  input beat_cnt_t issue_cnt
);

  // number of failed assertions so far
  int unsigned fail_cnt = 0;

  // stalled beat keeps bank, row and tag
  assert property (@(posedge clk) disable iff (!arst_n)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else begin
      fail_cnt++;
      $error("mem_req changed while stalled");
    end

  // presented feature held until taken
  assert property (@(posedge clk) disable iff (!arst_n)
    feat_valid && !feat_ready |=> feat_valid && $stable(feat))
    else begin
      fail_cnt++;
      $error("feat changed while held");
    end

  // next beat of the same burst is the next full word
  assert property (@(posedge clk) disable iff (!arst_n)
    mem_req_valid && mem_req_ready && (issue_cnt != beat_cnt_t'(BEATS - 1))
    |=> mem_req_valid && (full_word_t'({mem_req.row, mem_req.bank})
        == full_word_t'($past({mem_req.row, mem_req.bank}) + 1'b1)))
    else begin
      fail_cnt++;
      $error("burst beats not on consecutive full words");
    end

endmodule

bind burst_reader tile_burst_fetch_props u_props (.*);

// ==== dv/feat_sram_model.sv ====
`timescale 1ns/1ps

module feat_sram_model
  import sram_pkg::*;
  import fetch_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  // random ready stalls while set
  input  logic      mem_stall,
  input  logic      mem_req_valid,
  output logic      mem_req_ready,
  input  mem_req_t  mem_req,
  output logic      mem_rvalid,
  output mem_word_t mem_rdata
);

  // read pipeline, one slot per cycle of latency
  logic        vld_pipe [READ_LATENCY];
  mem_word_t   dat_pipe [READ_LATENCY];
  logic        fire;
  int unsigned full_word;

  initial begin
    mem_req_ready = 1'b1;
    mem_rvalid    = 1'b0;
    mem_rdata     = '0;
  end

  always @(posedge clk) begin
    // handshake as it stood just before the edge
    fire      = arst_n && mem_req_valid && mem_req_ready;
    // bank is the low part of the full word
    full_word = mem_req.row * BANKS + mem_req.bank;
    for (int i = READ_LATENCY - 1; i > 0; i--) begin
      vld_pipe[i] = vld_pipe[i-1];
      dat_pipe[i] = dat_pipe[i-1];
    end
    vld_pipe[0] = fire;
    // upper half the address, lower half its inverse
    dat_pipe[0] = {full_word, ~full_word};
    if (!arst_n) begin
      for (int i = 0; i < READ_LATENCY; i++) begin
        vld_pipe[i] = 1'b0;
      end
    end
    #1;
    mem_rvalid    = vld_pipe[READ_LATENCY-1];
    mem_rdata     = dat_pipe[READ_LATENCY-1];
    // ready low about one cycle in three when stalling
    mem_req_ready = !mem_stall || ($urandom % 3 != 0);
  end

endmodule

// ==== verilog/tile_burst_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_burst_fetch_top
  import sram_pkg::*;
  import fetch_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,

  // tile requests
  input  logic      req_valid,
  output logic      req_ready,
  input  tile_req_t req,

  // sram read requests
  output logic      mem_req_valid,
  input  logic      mem_req_ready,
  output mem_req_t  mem_req,

  // sram read data
  input  logic      mem_rvalid,
  input  mem_word_t mem_rdata,

  // packed features
  output logic      feat_valid,
  input  logic      feat_ready,
  output feat_out_t feat
);

  // ------------------------------------------------------------------
  // encoder -> queue -> reader
  // ------------------------------------------------------------------

  logic       enc_cmd_valid;
  logic       enc_cmd_ready;
  burst_cmd_t enc_cmd;

  logic       q_cmd_valid;
  logic       q_cmd_ready;
  burst_cmd_t q_cmd;

  tile_addr_encode u_enc (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .cmd_valid (enc_cmd_valid),
    .cmd_ready (enc_cmd_ready),
    .cmd       (enc_cmd)
  );

  // absorbs encoder output while the reader is busy
  fetch_cmd_queue u_queue (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr_valid (enc_cmd_valid),
    .wr_ready (enc_cmd_ready),
    .wr_cmd   (enc_cmd),
    .rd_valid (q_cmd_valid),
    .rd_ready (q_cmd_ready),
    .rd_cmd   (q_cmd)
  );

  burst_reader u_reader (
    .clk           (clk),
    .arst_n        (arst_n),
    .cmd_valid     (q_cmd_valid),
    .cmd_ready     (q_cmd_ready),
    .cmd           (q_cmd),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req       (mem_req),
    .mem_rvalid    (mem_rvalid),
    .mem_rdata     (mem_rdata),
    .feat_valid    (feat_valid),
    .feat_ready    (feat_ready),
    .feat          (feat)
  );

endmodule

`default_nettype wire

// ==== verilog/burst_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_reader
  import sram_pkg::*;
  import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,

  // burst command in
  input  logic       cmd_valid,
  output logic       cmd_ready,
  input  burst_cmd_t cmd,

  // per-beat sram read
  output logic       mem_req_valid,
  input  logic       mem_req_ready,
  output mem_req_t   mem_req,

  // sram return, fixed latency, no back-pressure
  input  logic       mem_rvalid,
  input  mem_word_t  mem_rdata,

  // packed feature out
  output logic       feat_valid,
  input  logic       feat_ready,
  output feat_out_t  feat
);

  // idle: wait for a command
  // issue: one read per beat
  // drain: all reads sent, returns still due
  // hold: feature presented until accepted
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_DRAIN,
    ST_HOLD
  } state_t;

  state_t state;

  // ------------------------------------------------------------------
  // burst state
  // ------------------------------------------------------------------

  // full word of the beat being issued
  full_word_t cur_word;
  tag_t       tag_q;
  // beats accepted by the sram
  beat_cnt_t  issue_cnt;
  // words returned so far, also the next lane
  beat_cnt_t  ret_cnt;
  feat_vec_t  vec_q;

  logic cmd_fire;
  logic mem_fire;
  logic ret_fire;
  logic issue_last;
  logic ret_last;

  assign cmd_ready = (state == ST_IDLE);
  assign cmd_fire  = cmd_valid && cmd_ready;

  assign mem_req_valid = (state == ST_ISSUE);
  assign mem_fire      = mem_req_valid && mem_req_ready;

  // returns only count while a burst is outstanding
  assign ret_fire = mem_rvalid && ((state == ST_ISSUE) || (state == ST_DRAIN));

  assign issue_last = (issue_cnt == beat_cnt_t'(BEATS - 1));
  assign ret_last   = (ret_cnt == beat_cnt_t'(BEATS - 1));

  // bank from the low bits, row from the rest
  assign mem_req.bank = cur_word[BANK_W-1:0];
  assign mem_req.row  = cur_word[FULL_WORD_W-1:BANK_W];
  assign mem_req.tag  = tag_q;

  assign feat_valid = (state == ST_HOLD);
  assign feat.vec   = vec_q;
  assign feat.tag   = tag_q;

  // ------------------------------------------------------------------
  // control
  // ------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= ST_IDLE;
      issue_cnt <= '0;
      ret_cnt   <= '0;
    end else begin
      unique case (state)
        ST_IDLE: begin
          if (cmd_fire) begin
            issue_cnt <= '0;
            ret_cnt   <= '0;
            state     <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          // early returns overlap with the later beats
          if (ret_fire) ret_cnt <= ret_cnt + 1'b1;
          if (mem_fire) begin
            issue_cnt <= issue_cnt + 1'b1;
            if (issue_last) state <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          if (ret_fire) begin
            ret_cnt <= ret_cnt + 1'b1;
            // last lane filled, present next cycle
            if (ret_last) state <= ST_HOLD;
          end
        end
        ST_HOLD: begin
          if (feat_ready) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      cur_word <= cmd.base_word;
      tag_q    <= cmd.tag;
    end else if (mem_fire) begin
      // consecutive full words, bank alternates
      cur_word <= cur_word + 1'b1;
    end
    // beat 0 lands in the lowest word
    if (ret_fire) vec_q[ret_cnt * MEM_W +: MEM_W] <= mem_rdata;
  end

endmodule

`default_nettype wire

// ==== verilog/fetch_cmd_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_cmd_queue
  import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,

  // write side, from the encoder
  input  logic       wr_valid,
  output logic       wr_ready,
  input  burst_cmd_t wr_cmd,

  // read side, to the burst reader
  output logic       rd_valid,
  input  logic       rd_ready,
  output burst_cmd_t rd_cmd
);

  localparam int unsigned PTR_W = $clog2(CMDQ_DEPTH);
  localparam int unsigned CNT_W = $clog2(CMDQ_DEPTH + 1);

  // storage
  burst_cmd_t mem [CMDQ_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // occupancy, 0..CMDQ_DEPTH
  logic [CNT_W-1:0] count;

  logic wr_fire;
  logic rd_fire;

  // full only when every slot holds a command
  assign wr_ready = (count != CNT_W'(CMDQ_DEPTH));
  assign rd_valid = (count != '0);
  assign wr_fire  = wr_valid && wr_ready;
  assign rd_fire  = rd_valid && rd_ready;

  // head entry straight from storage
  assign rd_cmd = mem[rd_ptr];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap naturally, depth is a power of two
      if (wr_fire) wr_ptr <= wr_ptr + 1'b1;
      if (rd_fire) rd_ptr <= rd_ptr + 1'b1;
      // simultaneous read and write leaves count unchanged
      if (wr_fire && !rd_fire) begin
        count <= count + 1'b1;
      end else if (rd_fire && !wr_fire) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) mem[wr_ptr] <= wr_cmd;
  end

endmodule

`default_nettype wire

// ==== verilog/tile_addr_encode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_addr_encode
  import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,

  // tile request in
  input  logic       req_valid,
  output logic       req_ready,
  input  tile_req_t  req,

  // burst command out
  output logic       cmd_valid,
  input  logic       cmd_ready,
  output burst_cmd_t cmd
);

  // ------------------------------------------------------------------
  // address arithmetic
  // ------------------------------------------------------------------

  // linear tile index, row major
  full_word_t tile_idx;
  // first full word of this tile's feature
  full_word_t base_word;

  logic       req_fire;
  logic       cmd_fire;
  logic       valid_q;
  burst_cmd_t cmd_q;

  // row * tiles-per-row + col
  assign tile_idx = full_word_t'(req.row) * full_word_t'(TILES_X)
                  + full_word_t'(req.col);

  // every tile owns BEATS consecutive full words
  assign base_word = full_word_t'(BASE_ADDR_WORD)
                   + tile_idx * full_word_t'(BEATS);

  // ------------------------------------------------------------------
  // one-entry output register
  // ------------------------------------------------------------------

  // accept when empty, or when the held command leaves this cycle
  assign req_ready = !valid_q || cmd_ready;
  assign req_fire  = req_valid && req_ready;
  assign cmd_fire  = valid_q && cmd_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (req_fire) begin
      // new command replaces a draining one
      valid_q <= 1'b1;
    end else if (cmd_fire) begin
      valid_q <= 1'b0;
    end
  end

  // payload only moves on an accepted request
  always_ff @(posedge clk) begin
    if (req_fire) begin
      cmd_q.base_word <= base_word;
      cmd_q.tag       <= req.tag;
    end
  end

  assign cmd_valid = valid_q;
  assign cmd       = cmd_q;

endmodule

`default_nettype wire

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;
  import sram_pkg::*;

  // ------------------------------------------------------------------
  // tile grid and feature layout
  // ------------------------------------------------------------------

  localparam int unsigned TILES_X = 16;
  localparam int unsigned TILES_Y = 8;
  localparam int unsigned FEAT_W = 256;
  // sram words per feature vector
  localparam int unsigned BEATS = FEAT_W / MEM_W;
  // first full word of the feature area
  localparam int unsigned BASE_ADDR_WORD = 256;
  // burst command buffer between encoder and reader
  localparam int unsigned CMDQ_DEPTH = 2;

  localparam int unsigned TILE_ROW_W = $clog2(TILES_Y);
  localparam int unsigned TILE_COL_W = $clog2(TILES_X);
  // full word = {row, bank}, bank in the low bits
  localparam int unsigned FULL_WORD_W = ROW_W + BANK_W;
  // must reach BEATS itself, hence the +1
  localparam int unsigned BEAT_CNT_W = $clog2(BEATS + 1);

  typedef logic [TILE_ROW_W-1:0]  tile_row_t;
  typedef logic [TILE_COL_W-1:0]  tile_col_t;
  typedef logic [FULL_WORD_W-1:0] full_word_t;
  typedef logic [BEAT_CNT_W-1:0]  beat_cnt_t;
  typedef logic [FEAT_W-1:0]      feat_vec_t;

  typedef struct packed {
    tile_row_t row;
    tile_col_t col;
    tag_t      tag;
  } tile_req_t;

  typedef struct packed {
    full_word_t base_word;
    tag_t       tag;
  } burst_cmd_t;

  typedef struct packed {
    feat_vec_t vec;
    tag_t      tag;
  } feat_out_t;

endpackage

// ==== verilog/sram_pkg.sv ====
package sram_pkg;

  // ------------------------------------------------------------------
  // feature sram geometry
  // ------------------------------------------------------------------

  // one read returns one word of this width
  localparam int unsigned MEM_W = 64;
  // interleaved banks, full word low bits pick the bank
  localparam int unsigned BANKS = 2;
  localparam int unsigned BANK_W = $clog2(BANKS);
  // per-bank row address
  localparam int unsigned ROW_W = 15;
  // request tag carried end to end
  localparam int unsigned TAG_W = 8;
  // accepted read -> rvalid, in cycles, always in order
  localparam int unsigned READ_LATENCY = 2;

  typedef logic [MEM_W-1:0]  mem_word_t;
  typedef logic [BANK_W-1:0] bank_t;
  typedef logic [ROW_W-1:0]  row_addr_t;
  typedef logic [TAG_W-1:0]  tag_t;

  // single-beat read request toward the sram
  typedef struct packed {
    bank_t     bank;
    row_addr_t row;
    tag_t      tag;
  } mem_req_t;

endpackage
